// File: source/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;                      // data, address or mask word

    localparam int MEM_WORDS  = 1024;                 // word_ram depth
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);    // word index width

    // one latched request as held by the request buffer
    typedef struct packed {
        logic  pending;
        logic  write;
        word_t addr;
        word_t wdata;
        word_t wmask;
    } mem_cmd_t;

    typedef enum logic [1:0] {
        ARB_IDLE,                                     // waiting for core strobes
        ARB_ISSUE,                                    // driving cmd_start on cpu bus
        ARB_WAIT_READ,                                // read in flight
        ARB_NOTIFY                                    // valid pulse to the core
    } arb_state_e;

    typedef enum logic [1:0] {
        SPL_IDLE,                                     // ready for a cpu command
        SPL_FIRST,                                    // low (or only) word access
        SPL_SECOND,                                   // high word access
        SPL_MERGE                                     // waiting for the last read word
    } split_state_e;

endpackage

// File: source/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;

    logic           cmd_start;
    logic           cmd_write;
    logic           cmd_ready;
    mem_pkg::word_t addr;
    mem_pkg::word_t wdata;
    mem_pkg::word_t wmask;                            // bit-granular write enable
    mem_pkg::word_t rdata;
    logic           rdata_valid;                      // one pulse per accepted read

    modport requester (
        output cmd_start,
        output cmd_write,
        output addr,
        output wdata,
        output wmask,
        input  cmd_ready,
        input  rdata,
        input  rdata_valid
    );

    modport memory (
        input  cmd_start,
        input  cmd_write,
        input  addr,
        input  wdata,
        input  wmask,
        output cmd_ready,
        output rdata,
        output rdata_valid
    );

endinterface

// File: source/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               inst_start,
    input  logic               d_cmd_start,
    input  logic               exited,
    input  mem_pkg::mem_cmd_t  inst_cmd,
    input  mem_pkg::mem_cmd_t  data_cmd,
    input  mem_pkg::mem_cmd_t  issue_cmd,
    output logic               inst_ready,
    output logic               d_cmd_ready,
    output logic               inst_valid,
    output logic               rdata_valid,
    output logic               capture,
    output logic               load_inst,
    output logic               load_data,
    output logic               sel_inst,
    mem_bus_if.requester       cpu_bus
);

    mem_pkg::arb_state_e state;
    mem_pkg::arb_state_e state_nx;
    logic                notify_inst;                 // result being notified is a fetch
    logic                accept;
    logic                issue_take;
    logic                read_done;

    // fetch always wins while it is still pending
    assign sel_inst = inst_cmd.pending;

    assign inst_ready  = (state == mem_pkg::ARB_IDLE) && !exited;
    assign d_cmd_ready = (state == mem_pkg::ARB_IDLE) && !exited;

    assign accept  = (inst_start && inst_ready) || (d_cmd_start && d_cmd_ready);
    assign capture = accept;                          // latch both requests at once

    assign cpu_bus.cmd_start = (state == mem_pkg::ARB_ISSUE) && !exited && cpu_bus.cmd_ready;
    assign cpu_bus.cmd_write = issue_cmd.write;
    assign cpu_bus.addr      = issue_cmd.addr;
    assign cpu_bus.wdata     = issue_cmd.wdata;
    assign cpu_bus.wmask     = issue_cmd.wmask;

    assign issue_take = cpu_bus.cmd_start;            // already qualified by ready
    assign read_done  = (state == mem_pkg::ARB_WAIT_READ) && !exited && cpu_bus.rdata_valid;

    assign load_inst = read_done && sel_inst;
    // a write retires as soon as the bus takes it
    assign load_data = (read_done && !sel_inst) || (issue_take && issue_cmd.write);

    assign inst_valid  = (state == mem_pkg::ARB_NOTIFY) && !exited && notify_inst;
    assign rdata_valid = (state == mem_pkg::ARB_NOTIFY) && !exited && !notify_inst;

    always_comb begin
        state_nx = state;
        case (state)
            mem_pkg::ARB_IDLE: begin
                if (accept) begin
                    state_nx = mem_pkg::ARB_ISSUE;
                end
            end
            mem_pkg::ARB_ISSUE: begin
                if (issue_take) begin
                    state_nx = issue_cmd.write ? mem_pkg::ARB_IDLE : mem_pkg::ARB_WAIT_READ;
                end
            end
            mem_pkg::ARB_WAIT_READ: begin
                if (read_done) begin
                    state_nx = mem_pkg::ARB_NOTIFY;
                end
            end
            mem_pkg::ARB_NOTIFY: begin
                if (!exited) begin
                    // data still queued behind the fetch goes straight out
                    state_nx = data_cmd.pending ? mem_pkg::ARB_ISSUE : mem_pkg::ARB_IDLE;
                end
            end
            default: state_nx = mem_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= mem_pkg::ARB_IDLE;
            notify_inst <= 1'b0;
        end else begin
            state <= state_nx;
            if (read_done) begin
                notify_inst <= sel_inst;
            end
        end
    end

    // a stalled command stays on the bus unchanged until the memory side takes it
    a_stall_keeps_cmd : assert property (
        @(posedge clk) disable iff (!rst_n)
        ((state == mem_pkg::ARB_ISSUE) && !issue_take) |=>
            (state == mem_pkg::ARB_ISSUE) && $stable(issue_cmd)
    );

    // one result at a time, and each pulse lasts a single cycle
    a_single_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        (inst_valid || rdata_valid) |->
            !(inst_valid && rdata_valid) ##1 !(inst_valid || rdata_valid)
    );

endmodule

// File: source/request_buffer.sv
`timescale 1ns/1ps

module request_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               capture,
    input  logic               load_inst,
    input  logic               load_data,
    input  logic               sel_inst,
    input  logic               inst_start,
    input  logic               d_cmd_start,
    input  logic               d_cmd_write,
    input  mem_pkg::word_t     i_addr,
    input  mem_pkg::word_t     d_addr,
    input  mem_pkg::word_t     wdata,
    input  mem_pkg::word_t     wmask,
    input  mem_pkg::word_t     bus_rdata,
    output mem_pkg::mem_cmd_t  inst_cmd,
    output mem_pkg::mem_cmd_t  data_cmd,
    output mem_pkg::mem_cmd_t  issue_cmd,
    output mem_pkg::word_t     inst,
    output mem_pkg::word_t     rdata
);

    logic           inst_pending;
    logic           data_pending;
    logic           data_write;
    mem_pkg::word_t inst_addr_q;
    mem_pkg::word_t data_addr_q;
    mem_pkg::word_t wdata_q;
    mem_pkg::word_t wmask_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_pending <= 1'b0;
            data_pending <= 1'b0;
            data_write   <= 1'b0;
            inst         <= '1;
            rdata        <= '1;
        end else if (capture) begin
            inst_pending <= inst_start;
            data_pending <= d_cmd_start;
            data_write   <= d_cmd_start && d_cmd_write;
        end else begin
            if (load_inst) begin
                inst_pending <= 1'b0;
                inst         <= bus_rdata;
            end
            if (load_data) begin
                data_pending <= 1'b0;
                if (!data_write) begin
                    rdata <= bus_rdata;           // writes leave the last read word
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            inst_addr_q <= i_addr;
            data_addr_q <= d_addr;
            wdata_q     <= wdata;
            wmask_q     <= wmask;
        end
    end

    assign inst_cmd  = '{pending: inst_pending, write: 1'b0, addr: inst_addr_q,
                         wdata: '0, wmask: '0};
    assign data_cmd  = '{pending: data_pending, write: data_write, addr: data_addr_q,
                         wdata: wdata_q, wmask: wmask_q};
    assign issue_cmd = sel_inst ? inst_cmd : data_cmd;

endmodule

// File: source/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl (
    input  logic          clk,
    input  logic          rst_n,
    mem_bus_if.memory     cpu_bus,
    mem_bus_if.requester  ram_bus
);

    mem_pkg::split_state_e               state;
    logic                                write_q;
    logic [1:0]                          off_q;      // byte offset of the access
    logic [mem_pkg::MEM_ADDR_W-1:0]      lo_idx;
    logic [mem_pkg::MEM_ADDR_W-1:0]      hi_idx;
    logic [63:0]                         data_q;     // wdata placed across two words
    logic [63:0]                         mask_q;
    mem_pkg::word_t                      lo_word;    // first half of a split read
    logic [63:0]                         data_sh;
    logic [63:0]                         mask_sh;
    logic [63:0]                         merged;
    logic                                split;
    logic                                sel_hi;
    logic                                lane_skip;
    mem_pkg::word_t                      lane_mask;
    logic                                want;
    logic                                cpu_take;
    logic                                ram_take;

    assign cpu_bus.cmd_ready = (state == mem_pkg::SPL_IDLE);
    assign cpu_take          = cpu_bus.cmd_start && cpu_bus.cmd_ready;

    assign data_sh = {32'b0, cpu_bus.wdata} << {cpu_bus.addr[1:0], 3'b000};
    assign mask_sh = {32'b0, cpu_bus.wmask} << {cpu_bus.addr[1:0], 3'b000};

    assign split  = (off_q != 2'b00);
    assign hi_idx = lo_idx + 1'b1;                   // wraps at the top of memory
    assign sel_hi = (state == mem_pkg::SPL_SECOND);

    assign lane_mask = sel_hi ? mask_q[63:32] : mask_q[31:0];
    assign lane_skip = write_q && split && (lane_mask == '0);   // nothing to write here
    assign want      = ((state == mem_pkg::SPL_FIRST) || sel_hi) && !lane_skip;

    assign ram_bus.cmd_start = want && ram_bus.cmd_ready;
    assign ram_bus.cmd_write = write_q;
    assign ram_bus.addr      = mem_pkg::word_t'(sel_hi ? hi_idx : lo_idx);
    assign ram_bus.wdata     = sel_hi ? data_q[63:32] : data_q[31:0];
    assign ram_bus.wmask     = lane_mask;
    assign ram_take          = ram_bus.cmd_start;

    // high word over low, then drop the leading offset bytes
    assign merged = {ram_bus.rdata, lo_word} >> {off_q, 3'b000};

    assign cpu_bus.rdata       = split ? merged[31:0] : ram_bus.rdata;
    assign cpu_bus.rdata_valid = (state == mem_pkg::SPL_MERGE) && ram_bus.rdata_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_pkg::SPL_IDLE;
        end else begin
            case (state)
                mem_pkg::SPL_IDLE: begin
                    if (cpu_take) begin
                        state <= mem_pkg::SPL_FIRST;
                    end
                end
                mem_pkg::SPL_FIRST: begin
                    if (lane_skip) begin
                        state <= mem_pkg::SPL_SECOND;
                    end else if (ram_take) begin
                        if (split) begin
                            state <= mem_pkg::SPL_SECOND;
                        end else begin
                            state <= write_q ? mem_pkg::SPL_IDLE : mem_pkg::SPL_MERGE;
                        end
                    end
                end
                mem_pkg::SPL_SECOND: begin
                    if (lane_skip) begin
                        state <= mem_pkg::SPL_IDLE;
                    end else if (ram_take) begin
                        state <= write_q ? mem_pkg::SPL_IDLE : mem_pkg::SPL_MERGE;
                    end
                end
                mem_pkg::SPL_MERGE: begin
                    if (ram_bus.rdata_valid) begin
                        state <= mem_pkg::SPL_IDLE;
                    end
                end
                default: state <= mem_pkg::SPL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_take) begin
            write_q <= cpu_bus.cmd_write;
            off_q   <= cpu_bus.addr[1:0];
            lo_idx  <= cpu_bus.addr[mem_pkg::MEM_ADDR_W+1:2];
            data_q  <= data_sh;
            mask_q  <= mask_sh;
        end
        if (sel_hi && ram_bus.rdata_valid) begin
            lo_word <= ram_bus.rdata;                // low word of a split read
        end
    end

    // returned words only belong to a read that is still being assembled
    a_rdata_expected : assert property (
        @(posedge clk) disable iff (!rst_n)
        ram_bus.rdata_valid |->
            !write_q && ((state == mem_pkg::SPL_SECOND) || (state == mem_pkg::SPL_MERGE))
    );

endmodule

// File: source/word_ram.sv
`timescale 1ns/1ps

module word_ram (
    input  logic       clk,
    input  logic       rst_n,
    mem_bus_if.memory  bus
);

    mem_pkg::word_t                  mem [mem_pkg::MEM_WORDS];
    mem_pkg::word_t                  rdata_q;
    logic                            ready_q;
    logic                            valid_q;
    logic [mem_pkg::MEM_ADDR_W-1:0]  idx;
    logic                            take;

    assign idx  = bus.addr[mem_pkg::MEM_ADDR_W-1:0];    // word address, wraps
    assign take = bus.cmd_start && ready_q;

    assign bus.cmd_ready   = ready_q;
    assign bus.rdata       = rdata_q;
    assign bus.rdata_valid = valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b1;
            valid_q <= 1'b0;
        end else if (take && !bus.cmd_write) begin
            ready_q <= 1'b0;                         // busy while the word is returned
            valid_q <= 1'b1;
        end else begin
            ready_q <= 1'b1;
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (bus.cmd_write) begin
                mem[idx] <= (mem[idx] & ~bus.wmask) | (bus.wdata & bus.wmask);
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    // requester has to respect the busy cycle after a read
    a_no_start_when_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        !bus.cmd_ready |-> !bus.cmd_start
    );

endmodule

// File: source/mem_port_top.sv
`timescale 1ns/1ps

module mem_port_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inst_start,
    output logic            inst_ready,
    input  mem_pkg::word_t  i_addr,
    output mem_pkg::word_t  inst,
    output logic            inst_valid,
    input  logic            d_cmd_start,
    input  logic            d_cmd_write,
    output logic            d_cmd_ready,
    input  mem_pkg::word_t  d_addr,
    input  mem_pkg::word_t  wdata,
    input  mem_pkg::word_t  wmask,
    output mem_pkg::word_t  rdata,
    output logic            rdata_valid,
    input  logic            exited
);

    mem_pkg::mem_cmd_t inst_cmd;
    mem_pkg::mem_cmd_t data_cmd;
    mem_pkg::mem_cmd_t issue_cmd;
    logic              capture;
    logic              load_inst;
    logic              load_data;
    logic              sel_inst;

    mem_bus_if cpu_bus ();                           // arbiter to access controller
    mem_bus_if ram_bus ();                           // access controller to storage

    mem_arbiter i_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_start  (inst_start),
        .d_cmd_start (d_cmd_start),
        .exited      (exited),
        .inst_cmd    (inst_cmd),
        .data_cmd    (data_cmd),
        .issue_cmd   (issue_cmd),
        .inst_ready  (inst_ready),
        .d_cmd_ready (d_cmd_ready),
        .inst_valid  (inst_valid),
        .rdata_valid (rdata_valid),
        .capture     (capture),
        .load_inst   (load_inst),
        .load_data   (load_data),
        .sel_inst    (sel_inst),
        .cpu_bus     (cpu_bus.requester)
    );

    request_buffer i_request_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture     (capture),
        .load_inst   (load_inst),
        .load_data   (load_data),
        .sel_inst    (sel_inst),
        .inst_start  (inst_start),
        .d_cmd_start (d_cmd_start),
        .d_cmd_write (d_cmd_write),
        .i_addr      (i_addr),
        .d_addr      (d_addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .bus_rdata   (cpu_bus.rdata),
        .inst_cmd    (inst_cmd),
        .data_cmd    (data_cmd),
        .issue_cmd   (issue_cmd),
        .inst        (inst),
        .rdata       (rdata)
    );

    mem_access_ctrl i_access_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_bus (cpu_bus.memory),
        .ram_bus (ram_bus.requester)
    );

    word_ram i_word_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (ram_bus.memory)
    );

endmodule

// File: sim/mem_port_tb.sv
`timescale 1ns/1ps

module mem_port_tb;

    localparam int          CLK_PERIOD = 20;
    localparam int          TIMEOUT    = 50;              // cycles per wait
    localparam logic [16:0] SEED       = 17'd98767;

    logic           clk;
    logic           rst_n;
    logic           inst_start;
    logic           inst_ready;
    mem_pkg::word_t i_addr;
    mem_pkg::word_t inst;
    logic           inst_valid;
    logic           d_cmd_start;
    logic           d_cmd_write;
    logic           d_cmd_ready;
    mem_pkg::word_t d_addr;
    mem_pkg::word_t wdata;
    mem_pkg::word_t wmask;
    mem_pkg::word_t rdata;
    logic           rdata_valid;
    logic           exited;
    logic [16:0]    lfsr;

    mem_port_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // fibonacci, x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string test, input mem_pkg::word_t expected,
                              input mem_pkg::word_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("CHECK FAILED %s expected %08h actual %08h",
                               test, expected, actual));
        end
    endtask

    task automatic check_flag(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_run($sformatf("CHECK FAILED %s expected %b actual %b", test, expected, actual));
        end
    endtask

    // outputs are sampled and inputs driven 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_ready(input string test);
        int n;
        n = 0;
        while (!(inst_ready && d_cmd_ready)) begin
            if (n == TIMEOUT) begin
                stop_run($sformatf("timeout in %s while waiting for the port to be ready", test));
            end
            next_cycle();
            n++;
        end
    endtask

    // the other result must not show up first
    task automatic wait_pulse(input string test, input logic data_side);
        int n;
        n = 0;
        while (!(data_side ? rdata_valid : inst_valid)) begin
            check_flag({test, " order"}, 1'b0, data_side ? inst_valid : rdata_valid);
            if (n == TIMEOUT) begin
                stop_run($sformatf("timeout in %s while waiting for %s", test,
                                   data_side ? "rdata_valid" : "inst_valid"));
            end
            next_cycle();
            n++;
        end
        check_flag({test, " one result"}, 1'b0, data_side ? inst_valid : rdata_valid);
    endtask

    task automatic issue_request(input logic fetch, input logic data, input logic write,
                                 input mem_pkg::word_t ia, input mem_pkg::word_t da,
                                 input mem_pkg::word_t wd, input mem_pkg::word_t wm);
        inst_start  = fetch;
        d_cmd_start = data;
        d_cmd_write = write;
        i_addr      = ia;
        d_addr      = da;
        wdata       = wd;
        wmask       = wm;
        next_cycle();
        inst_start  = 1'b0;                               // one-cycle strobes
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
    endtask

    task automatic take_result(input string test, input logic data_side,
                               input mem_pkg::word_t expected);
        wait_pulse(test, data_side);
        check_word(test, expected, data_side ? rdata : inst);
        next_cycle();
        check_flag({test, " pulse width"}, 1'b0, data_side ? rdata_valid : inst_valid);
    endtask

    task automatic run_exited(input string test, input mem_pkg::word_t addr,
                              input mem_pkg::word_t expected);
        exited = 1'b1;
        next_cycle();
        check_flag({test, " inst_ready"}, 1'b0, inst_ready);
        check_flag({test, " d_cmd_ready"}, 1'b0, d_cmd_ready);
        issue_request(1'b1, 1'b0, 1'b0, addr, '0, '0, '0);
        repeat (TIMEOUT) begin
            check_flag({test, " frozen"}, 1'b0, inst_valid || rdata_valid);
            next_cycle();
        end
        exited = 1'b0;
        next_cycle();
        wait_ready(test);
        issue_request(1'b1, 1'b0, 1'b0, addr, '0, '0, '0);
        take_result(test, 1'b0, expected);
    endtask

    initial begin
        string          line;
        string          kind;
        string          name;
        mem_pkg::word_t addr;
        mem_pkg::word_t addr2;
        mem_pkg::word_t wd;
        mem_pkg::word_t wm;
        mem_pkg::word_t expected;
        int             fd;
        int             n;
        int             gap;
        clk         = 1'b0;
        rst_n       = 1'b0;
        inst_start  = 1'b0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        i_addr      = '0;
        d_addr      = '0;
        wdata       = '0;
        wmask       = '0;
        exited      = 1'b0;
        lfsr        = SEED;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        check_flag("reset inst_valid", 1'b0, inst_valid);
        check_flag("reset rdata_valid", 1'b0, rdata_valid);
        check_flag("reset inst_ready", 1'b1, inst_ready);
        check_flag("reset d_cmd_ready", 1'b1, d_cmd_ready);
        check_word("reset inst", '1, inst);
        check_word("reset rdata", '1, rdata);
        fd = $fopen("sim/mem_vectors.txt", "r");
        if (fd == 0) begin
            stop_run("could not open the vector file sim/mem_vectors.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %h %h",
                            kind, name, addr, addr2, wd, wm, expected);
                if (n != 7) begin
                    stop_run({"vector line could not be parsed: ", line});
                end
                wait_ready(name);
                case (kind)
                    "W": issue_request(1'b0, 1'b1, 1'b1, '0, addr, wd, wm);
                    "R": begin
                        issue_request(1'b0, 1'b1, 1'b0, '0, addr, '0, '0);
                        take_result(name, 1'b1, expected);
                    end
                    "I": begin
                        issue_request(1'b1, 1'b0, 1'b0, addr, '0, '0, '0);
                        take_result(name, 1'b0, expected);
                    end
                    "B": begin
                        issue_request(1'b1, 1'b1, 1'b0, addr, addr2, '0, '0);
                        take_result(name, 1'b0, wd);      // fetch word sits in wdata column
                        take_result(name, 1'b1, expected);
                    end
                    "X": run_exited(name, addr, expected);
                    default: stop_run({"unknown operation kind in vector file: ", kind});
                endcase
                lfsr = lfsr_step(lfsr);                   // two bits for a 0..3 gap
                gap  = lfsr[0];
                lfsr = lfsr_step(lfsr);
                gap  = gap * 2 + lfsr[0];
                repeat (gap) next_cycle();
            end
        end
        $fclose(fd);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: vlog.f
source/mem_pkg.sv
source/mem_bus_if.sv
source/mem_arbiter.sv
source/request_buffer.sv
source/mem_access_ctrl.sv
source/word_ram.sv
source/mem_port_top.sv
sim/mem_port_tb.sv

// File: sim/mem_vectors.txt
# kind name byte_addr second_addr wdata wmask expected, all hex; W write R read I fetch
# B fetch(addr)+read(second_addr), fetch word in wdata; X fetch blocked by exited, then retried
W init_w100   00000100 00000000 11223344 ffffffff 00000000
W mask_w100   00000100 00000000 aabbccdd 0000ffff 00000000
R read_w100   00000100 00000000 00000000 00000000 1122ccdd
W bits_w100   00000100 00000000 ffffffff 80000001 00000000
R rbits_w100  00000100 00000000 00000000 00000000 9122ccdd
I fetch_w100  00000100 00000000 00000000 00000000 9122ccdd
W init_w200   00000200 00000000 03020100 ffffffff 00000000
W init_w204   00000204 00000000 07060504 ffffffff 00000000
W mis1_write  00000201 00000000 ddccbbaa ffffffff 00000000
R mis1_lo     00000200 00000000 00000000 00000000 ccbbaa00
R mis1_hi     00000204 00000000 00000000 00000000 070605dd
R mis1_read   00000201 00000000 00000000 00000000 ddccbbaa
W init_w300   00000300 00000000 13121110 ffffffff 00000000
W init_w304   00000304 00000000 17161514 ffffffff 00000000
W mis2_write  00000302 00000000 44332211 ffffffff 00000000
R mis2_lo     00000300 00000000 00000000 00000000 22111110
R mis2_hi     00000304 00000000 00000000 00000000 17164433
R mis2_read   00000302 00000000 00000000 00000000 44332211
W init_wffc   00000ffc 00000000 2b2a2928 ffffffff 00000000
W init_w000   00000000 00000000 2f2e2d2c ffffffff 00000000
W mis3_write  00000fff 00000000 87654321 00ffff00 00000000
R mis3_lo     00000ffc 00000000 00000000 00000000 2b2a2928
R mis3_hi     00000000 00000000 00000000 00000000 2f2e6543
R mis3_read   00000fff 00000000 00000000 00000000 2e65432b
I fetch_w304  00000304 00000000 00000000 00000000 17164433
B both_align  00000100 00000204 9122ccdd 00000000 070605dd
B both_split  00000300 00000201 22111110 00000000 ddccbbaa
X exited_hold 00000200 00000000 00000000 00000000 ccbbaa00
